// File: all.f
logic/dcache_pkg.sv
logic/dcache_sram.sv
logic/dcache_lookup.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/dcache_assertions.sv
verif/dcache_tb.sv

// File: verif/dcache_tb.sv
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_ops         = 600;
    localparam int slot_num        = 16;  // 4 tags in 4 sets
    localparam int op_cycles       = 200;
    localparam int reset_cycles    = 16;
    localparam int watchdog_cycles = (num_ops + 4) * op_cycles + dcache_pkg::set_num
                                   + reset_cycles;

    logic                        clock;
    logic                        reset_n;
    logic                        cpu_valid;
    dcache_pkg::cpu_req_t        cpu_req;
    wire                         cpu_ready;
    wire                         cpu_done;
    wire dcache_pkg::word_t      cpu_rdata;
    wire                         mem_valid;
    logic                        mem_ready;
    wire dcache_pkg::mem_req_t   mem_req;
    logic                        mem_done;
    dcache_pkg::line_t           mem_rline;

    logic [dcache_pkg::tag_w-1:0]   tag_pool [4] = '{17'h00001, 17'h0abcd, 17'h1ffff, 17'h12345};
    logic [dcache_pkg::index_w-1:0] set_pool [4] = '{9'h000, 9'h001, 9'h0a5, 9'h1ff};

    dcache_pkg::line_t     main_mem [slot_num];
    dcache_pkg::word_t     model_mem [slot_num * dcache_pkg::bank_num];  // expected read values
    dcache_pkg::cpu_req_t  cur_req;
    int                    mem_count = 0;

    dcache_top uut (
        .clock     (clock),
        .reset_n   (reset_n),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_done  (cpu_done),
        .cpu_rdata (cpu_rdata),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_req   (mem_req),
        .mem_done  (mem_done),
        .mem_rline (mem_rline)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic dcache_pkg::cache_addr_t slot_addr(int slot, int bank);
        dcache_pkg::cache_addr_t a;
        a.tag    = tag_pool[slot / 4];
        a.index  = set_pool[slot % 4];
        a.bank   = bank[dcache_pkg::bank_w-1:0];
        a.offset = '0;
        return a;
    endfunction

    function automatic dcache_pkg::cache_addr_t line_base(dcache_pkg::cache_addr_t a);
        dcache_pkg::cache_addr_t b;
        b        = a;
        b.bank   = '0;
        b.offset = '0;
        return b;
    endfunction

    function automatic int find_slot(dcache_pkg::cache_addr_t a);
        int found;
        found = -1;
        for (int s = 0; s < slot_num; s++) begin
            if (tag_pool[s / 4] == a.tag && set_pool[s % 4] == a.index) found = s;
        end
        return found;
    endfunction

    // memory contents at start, built from the full byte address
    function automatic dcache_pkg::word_t init_word(int slot, int bank);
        dcache_pkg::cache_addr_t a;
        a = slot_addr(slot, bank);
        return {32'(a) ^ 32'h3c5a_96e1, 32'(a)};
    endfunction

    function automatic dcache_pkg::line_t model_line(int slot);
        dcache_pkg::line_t l;
        for (int b = 0; b < dcache_pkg::bank_num; b++) begin
            l[b] = model_mem[slot * dcache_pkg::bank_num + b];
        end
        return l;
    endfunction

    function automatic dcache_pkg::cpu_req_t make_req(int slot, int bank, bit write);
        dcache_pkg::cpu_req_t r;
        r.addr  = slot_addr(slot, bank);
        r.write = write;
        r.wdata = '0;
        r.wmask = '0;
        return r;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t expected);
        if (got !== expected) begin
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, expected);
            stop_run("word value mismatch");
        end
    endtask

    task automatic check_line(input string name, input dcache_pkg::line_t got,
                              input dcache_pkg::line_t expected);
        if (got !== expected) begin
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, expected);
            stop_run("line value mismatch");
        end
    endtask

    task automatic check_addr(input string name, input dcache_pkg::cache_addr_t got,
                              input dcache_pkg::cache_addr_t expected);
        if (got !== expected) begin
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, expected);
            stop_run("address mismatch");
        end
    endtask

    // memory side, random ready and done delays
    task automatic serve_memory();
        dcache_pkg::mem_req_t req;
        int slot;
        forever begin
            @(negedge clock);
            if (mem_valid && $urandom_range(0, 2) == 0) begin
                req       = mem_req;
                mem_ready = 1'b1;  // accepted at the next rising edge
                mem_count++;
                slot = find_slot(req.addr);
                if (slot < 0) stop_run("memory request outside the tested lines");
                check_addr("mem_req.addr", req.addr, line_base(req.addr));
                if (req.write) begin
                    check_line("mem_req.wline", req.wline, model_line(slot));
                    main_mem[slot] = req.wline;
                end else begin
                    check_addr("mem_req.addr", req.addr, line_base(cur_req.addr));
                end
                @(negedge clock);
                mem_ready = 1'b0;
                repeat ($urandom_range(0, 5)) @(negedge clock);
                mem_done = 1'b1;
                if (!req.write) mem_rline = main_mem[slot];
                @(negedge clock);
                mem_done  = 1'b0;
                mem_rline = '0;
            end
        end
    endtask

    task automatic run_access(input dcache_pkg::cpu_req_t req, input bit expect_hit);
        int slot;
        int idx;
        int cycles;
        int mem_before;
        slot = find_slot(req.addr);
        idx  = slot * dcache_pkg::bank_num + req.addr.bank;
        while (!cpu_ready) @(negedge clock);
        cur_req    = req;
        mem_before = mem_count;
        cpu_req    = req;
        cpu_valid  = 1'b1;
        cycles     = 0;
        do begin
            @(negedge clock);
            cpu_valid = 1'b0;
            cycles++;
            if (cycles > op_cycles) stop_run("no cpu_done after a request");
        end while (!cpu_done);
        if (mem_valid) stop_run("request answered while a memory request was pending");
        if (req.write) begin
            check_word("cpu_rdata", cpu_rdata, '0);
            model_mem[idx] = (req.wdata & req.wmask) | (model_mem[idx] & ~req.wmask);
        end else begin
            check_word("cpu_rdata", cpu_rdata, model_mem[idx]);
        end
        if (expect_hit) begin
            if (mem_count != mem_before) stop_run("memory traffic on an access that should hit");
            if (cycles != 2) begin
                stop_run($sformatf("hit answered %0d edges after acceptance, expected 2",
                                   cycles));
            end
        end
    endtask

    initial begin
        dcache_pkg::cpu_req_t req;
        int slot;
        int last_slot;
        bit reuse;
        void'($urandom(32'hfa49_61cc));
        reset_n   = 1'b0;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        mem_ready = 1'b0;
        mem_done  = 1'b0;
        mem_rline = '0;
        cur_req   = '0;
        for (int s = 0; s < slot_num; s++) begin
            for (int b = 0; b < dcache_pkg::bank_num; b++) begin
                main_mem[s][b] = init_word(s, b);
                model_mem[s * dcache_pkg::bank_num + b] = init_word(s, b);
            end
        end
        fork
            serve_memory();
        join_none
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        while (!cpu_ready) @(negedge clock);  // tag sweep

        // two lines of set 0 fill both ways and stay
        run_access(make_req(0, 0, 1'b0), 1'b0);
        run_access(make_req(4, 1, 1'b0), 1'b0);
        run_access(make_req(0, 3, 1'b0), 1'b1);
        run_access(make_req(4, 5, 1'b0), 1'b1);
        last_slot = 4;

        for (int n = 0; n < num_ops; n++) begin
            reuse = ($urandom_range(0, 3) == 0);
            slot  = reuse ? last_slot : $urandom_range(0, slot_num - 1);
            req   = make_req(slot, $urandom_range(0, dcache_pkg::bank_num - 1),
                             $urandom_range(0, 1));
            if (req.write) begin
                req.wdata = {$urandom, $urandom};
                case ($urandom_range(0, 2))
                    0: req.wmask = '1;
                    1: req.wmask = {$urandom, $urandom};
                    default: req.wmask = 64'hff << (8 * $urandom_range(0, 7));  // one byte
                endcase
            end
            run_access(req, reuse);
            last_slot = slot;
        end

        @(negedge clock);
        if (uut.u_assertions.fail_count != 0) begin
            stop_run("a bound assertion failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    always @(negedge clock) begin
        if (uut.u_assertions.fail_count != 0) stop_run("a bound assertion failed");
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        stop_run($sformatf("timeout, run not finished after %0d cycles", watchdog_cycles));
    end

endmodule

`default_nettype wire

// File: verif/dcache_assertions.sv
`default_nettype none

module dcache_assertions (
    input wire                        clock,
    input wire                        reset_n,
    input wire                        cpu_ready,
    input wire                        cpu_done,
    input wire                        mem_valid,
    input wire                        mem_ready,
    input wire dcache_pkg::mem_req_t  mem_req
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // polled from the testbench top

    // done never lasts longer than one cycle
    done_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        cpu_done |=> !cpu_done)
    else begin
        $error("cpu_done stayed high for more than one cycle");
        fail_count++;
    end

    // request held while memory is not ready
    mem_hold: assert property (@(posedge clock) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
    else begin
        $error("mem_valid or mem_req changed before mem_ready");
        fail_count++;
    end

    busy_excl: assert property (@(posedge clock) disable iff (!reset_n)
        !(mem_valid && cpu_ready))  // no new request while memory is busy
    else begin
        $error("mem_valid and cpu_ready high together");
        fail_count++;
    end

endmodule

bind dcache_top dcache_assertions u_assertions (
    .clock     (clock),
    .reset_n   (reset_n),
    .cpu_ready (cpu_ready),
    .cpu_done  (cpu_done),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_req   (mem_req)
);

`default_nettype wire

// File: logic/dcache_top.sv
`default_nettype none

module dcache_top (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire                         cpu_valid,
    input  wire dcache_pkg::cpu_req_t   cpu_req,
    output wire                         cpu_ready,
    output wire                         cpu_done,
    output wire dcache_pkg::word_t      cpu_rdata,
    output wire                         mem_valid,
    input  wire                         mem_ready,
    output wire dcache_pkg::mem_req_t   mem_req,
    input  wire                         mem_done,
    input  wire dcache_pkg::line_t      mem_rline
);

    wire [dcache_pkg::index_w-1:0]  tag_rindex;
    wire [dcache_pkg::index_w-1:0]  tag_windex;
    wire [dcache_pkg::index_w-1:0]  data_rindex;
    wire [dcache_pkg::index_w-1:0]  data_windex;
    wire dcache_pkg::tag_set_t      tag_rset;
    wire dcache_pkg::tag_set_t      tag_wset;
    wire                            tag_we;
    wire [dcache_pkg::way_num-1:0]  data_we;
    wire dcache_pkg::line_t         data_rline0;
    wire dcache_pkg::line_t         data_rline1;
    wire dcache_pkg::line_t         data_wline;
    wire [dcache_pkg::tag_w-1:0]    lookup_tag;
    wire dcache_pkg::lookup_t       lookup;

    dcache_ctrl u_ctrl (
        .clock       (clock),
        .reset_n     (reset_n),
        .cpu_valid   (cpu_valid),
        .cpu_req     (cpu_req),
        .cpu_ready   (cpu_ready),
        .cpu_done    (cpu_done),
        .cpu_rdata   (cpu_rdata),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_req     (mem_req),
        .mem_done    (mem_done),
        .mem_rline   (mem_rline),
        .tag_rindex  (tag_rindex),
        .tag_rset    (tag_rset),
        .tag_we      (tag_we),
        .tag_windex  (tag_windex),
        .tag_wset    (tag_wset),
        .data_rindex (data_rindex),
        .data_rline0 (data_rline0),
        .data_rline1 (data_rline1),
        .data_we     (data_we),
        .data_windex (data_windex),
        .data_wline  (data_wline),
        .lookup_tag  (lookup_tag),
        .lookup      (lookup)
    );

    dcache_lookup u_lookup (
        .clock    (clock),
        .reset_n  (reset_n),
        .tag_set  (tag_rset),
        .addr_tag (lookup_tag),
        .result   (lookup)
    );

    // both ways' tags in one entry
    dcache_sram #(
        .entry_t (dcache_pkg::tag_set_t),
        .depth   (dcache_pkg::set_num)
    ) u_tag_sram (
        .clock        (clock),
        .read_index   (tag_rindex),
        .read_entry   (tag_rset),
        .write_enable (tag_we),
        .write_index  (tag_windex),
        .write_entry  (tag_wset)
    );

    dcache_sram #(
        .entry_t (dcache_pkg::line_t),
        .depth   (dcache_pkg::set_num)
    ) u_data_sram0 (
        .clock        (clock),
        .read_index   (data_rindex),
        .read_entry   (data_rline0),
        .write_enable (data_we[0]),
        .write_index  (data_windex),
        .write_entry  (data_wline)
    );

    dcache_sram #(
        .entry_t (dcache_pkg::line_t),
        .depth   (dcache_pkg::set_num)
    ) u_data_sram1 (
        .clock        (clock),
        .read_index   (data_rindex),
        .read_entry   (data_rline1),
        .write_enable (data_we[1]),
        .write_index  (data_windex),
        .write_entry  (data_wline)
    );

endmodule

`default_nettype wire

// File: logic/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  wire                                clock,
    input  wire                                reset_n,
    input  wire                                cpu_valid,
    input  wire dcache_pkg::cpu_req_t          cpu_req,
    output logic                               cpu_ready,
    output logic                               cpu_done,
    output dcache_pkg::word_t                  cpu_rdata,
    output logic                               mem_valid,
    input  wire                                mem_ready,
    output dcache_pkg::mem_req_t               mem_req,
    input  wire                                mem_done,
    input  wire dcache_pkg::line_t             mem_rline,
    output logic [dcache_pkg::index_w-1:0]     tag_rindex,
    input  wire dcache_pkg::tag_set_t          tag_rset,
    output logic                               tag_we,
    output logic [dcache_pkg::index_w-1:0]     tag_windex,
    output dcache_pkg::tag_set_t               tag_wset,
    output logic [dcache_pkg::index_w-1:0]     data_rindex,
    input  wire dcache_pkg::line_t             data_rline0,
    input  wire dcache_pkg::line_t             data_rline1,
    output logic [dcache_pkg::way_num-1:0]     data_we,
    output logic [dcache_pkg::index_w-1:0]     data_windex,
    output dcache_pkg::line_t                  data_wline,
    output logic [dcache_pkg::tag_w-1:0]       lookup_tag,
    input  wire dcache_pkg::lookup_t           lookup
);

    dcache_pkg::state_t      state, next_state;
    dcache_pkg::cpu_req_t    req_q;
    dcache_pkg::lookup_t     lookup_q;
    dcache_pkg::tag_set_t    tag_set_q;
    dcache_pkg::line_t       line0_q, line1_q, fill_q;
    dcache_pkg::line_t       live_hit_line, hit_line, victim_line;
    dcache_pkg::word_t       rdata_q;
    logic                    done_q;
    logic                    mem_sent;
    logic [dcache_pkg::index_w:0] sweep_cnt;
    logic                    sweeping;

    // store word merged into its bank under the bit mask
    function automatic dcache_pkg::line_t merge_line(dcache_pkg::line_t old_line,
                                                     dcache_pkg::cpu_req_t req);
        dcache_pkg::line_t new_line;
        new_line = old_line;
        new_line[req.addr.bank] = (req.wdata & req.wmask)
                                | (old_line[req.addr.bank] & ~req.wmask);
        return new_line;
    endfunction

    assign sweeping = !sweep_cnt[dcache_pkg::index_w];  // msb set once all sets cleared
    assign cpu_ready = (state == dcache_pkg::idle) && !sweeping;
    assign cpu_done  = done_q;
    assign cpu_rdata = rdata_q;

    // read at the accepting edge so lookup sees the set one cycle later
    assign tag_rindex  = (state == dcache_pkg::idle) ? cpu_req.addr.index : req_q.addr.index;
    assign data_rindex = tag_rindex;
    assign lookup_tag  = req_q.addr.tag;

    assign live_hit_line = lookup.hit_way ? data_rline1 : data_rline0;
    assign hit_line      = lookup_q.hit_way ? line1_q : line0_q;
    assign victim_line   = lookup_q.victim_way ? line1_q : line0_q;

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::idle:
                if (cpu_valid && cpu_ready) next_state = dcache_pkg::lookup;
            dcache_pkg::lookup:
                if (lookup.hit) begin
                    next_state = req_q.write ? dcache_pkg::hit_write : dcache_pkg::idle;
                end else if (lookup.victim_dirty) begin
                    next_state = dcache_pkg::write_back;
                end else begin
                    next_state = dcache_pkg::refill_fetch;
                end
            dcache_pkg::hit_write: next_state = dcache_pkg::idle;
            dcache_pkg::write_back:
                if (mem_sent && mem_done) next_state = dcache_pkg::refill_fetch;
            dcache_pkg::refill_fetch:
                if (mem_sent && mem_done) next_state = dcache_pkg::refill;
            default: next_state = dcache_pkg::idle;  // refill
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= dcache_pkg::idle;
            sweep_cnt <= '0;
            mem_sent  <= 1'b0;
            lookup_q  <= '0;
            done_q    <= 1'b0;
            rdata_q   <= '0;
        end else begin
            state  <= next_state;
            done_q <= 1'b0;
            if (sweeping) sweep_cnt <= sweep_cnt + 1'b1;
            if (mem_valid && mem_ready) begin
                mem_sent <= 1'b1;
            end else if (mem_done) begin
                mem_sent <= 1'b0;
            end
            if (state == dcache_pkg::lookup) begin
                lookup_q <= lookup;
                if (lookup.hit) begin  // both hit kinds answer here
                    done_q  <= 1'b1;
                    rdata_q <= req_q.write ? '0 : live_hit_line[req_q.addr.bank];
                end
            end
            if (state == dcache_pkg::refill) begin
                done_q  <= 1'b1;
                rdata_q <= req_q.write ? '0 : fill_q[req_q.addr.bank];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cpu_valid && cpu_ready) req_q <= cpu_req;
        if (state == dcache_pkg::lookup) begin
            tag_set_q <= tag_rset;
            line0_q   <= data_rline0;
            line1_q   <= data_rline1;
        end
        if (state == dcache_pkg::refill_fetch && mem_done) begin
            fill_q <= req_q.write ? merge_line(mem_rline, req_q) : mem_rline;
        end
    end

    assign mem_valid = (state == dcache_pkg::write_back || state == dcache_pkg::refill_fetch)
                     && !mem_sent;

    always_comb begin
        mem_req             = '0;
        mem_req.addr.index  = req_q.addr.index;
        if (state == dcache_pkg::write_back) begin
            mem_req.write    = 1'b1;
            mem_req.addr.tag = lookup_q.victim_tag;
            mem_req.wline    = victim_line;  // whole dirty line
        end else begin
            mem_req.addr.tag = req_q.addr.tag;
        end
    end

    assign tag_we     = sweeping || state == dcache_pkg::hit_write
                      || state == dcache_pkg::refill;
    assign tag_windex = sweeping ? sweep_cnt[dcache_pkg::index_w-1:0] : req_q.addr.index;

    always_comb begin
        tag_wset = tag_set_q;
        if (sweeping) begin
            tag_wset = '0;
        end else if (state == dcache_pkg::hit_write) begin
            tag_wset[lookup_q.hit_way].dirty = 1'b1;
        end else begin
            tag_wset[lookup_q.victim_way] = '{valid: 1'b1, dirty: req_q.write,
                                              tag: req_q.addr.tag};
        end
    end

    always_comb begin
        data_we = '0;
        if (state == dcache_pkg::hit_write) begin
            data_we[lookup_q.hit_way] = 1'b1;
        end else if (state == dcache_pkg::refill) begin
            data_we[lookup_q.victim_way] = 1'b1;
        end
    end

    assign data_windex = req_q.addr.index;
    // read-modify-write of the whole line on a store hit
    assign data_wline  = (state == dcache_pkg::hit_write) ? merge_line(hit_line, req_q) : fill_q;

endmodule

`default_nettype wire

// File: logic/dcache_lookup.sv
`default_nettype none

module dcache_lookup (
    input  wire                              clock,
    input  wire                              reset_n,
    input  wire dcache_pkg::tag_set_t        tag_set,
    input  wire [dcache_pkg::tag_w-1:0]      addr_tag,
    output dcache_pkg::lookup_t              result
);

    logic [7:0]                      lfsr;
    logic                            lfsr_fb;
    logic [dcache_pkg::way_num-1:0]  way_valid;
    logic [dcache_pkg::way_num-1:0]  way_hit;
    logic                            set_full;
    logic                            victim;

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= dcache_pkg::lfsr_seed;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};  // free running
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            way_valid[w] = tag_set[w].valid;
            way_hit[w]   = tag_set[w].valid && (tag_set[w].tag == addr_tag);
        end
    end

    assign set_full = &way_valid;

    // lowest invalid way first, random pick once the set is full
    assign victim = set_full ? lfsr[0] : way_valid[0];

    always_comb begin
        result              = '0;
        result.hit          = |way_hit;
        result.hit_way      = way_hit[1];
        result.victim_way   = victim;
        result.victim_dirty = tag_set[victim].valid && tag_set[victim].dirty;
        result.victim_tag   = tag_set[victim].tag;  // for the write-back address
    end

endmodule

`default_nettype wire

// File: logic/dcache_sram.sv
`default_nettype none

module dcache_sram #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 512
) (
    input  wire                     clock,
    input  wire [$clog2(depth)-1:0] read_index,
    output entry_t                  read_entry,
    input  wire                     write_enable,
    input  wire [$clog2(depth)-1:0] write_index,
    input  wire entry_t             write_entry
);

    entry_t mem [depth];

    // single array, one read and one write port
    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[write_index] <= write_entry;
        end
    end

    // registered read, old data on a same-index write
    always_ff @(posedge clock) begin
        read_entry <= mem[read_index];
    end

endmodule

`default_nettype wire

// File: logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // address geometry
    localparam int addr_w   = 32;
    localparam int index_w  = 9;
    localparam int bank_w   = 3;
    localparam int offset_w = 3;
    localparam int tag_w    = addr_w - index_w - bank_w - offset_w;  // 17

    localparam int word_w   = 64;
    localparam int bank_num = 1 << bank_w;   // words per line
    localparam int way_num  = 2;
    localparam int set_num  = 1 << index_w;

    localparam logic [7:0] lfsr_seed = 8'hff;

    typedef logic [word_w-1:0] word_t;
    typedef word_t [bank_num-1:0] line_t;  // bank 0 in the low bits

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [bank_w-1:0]   bank;
        logic [offset_w-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    typedef tag_entry_t [way_num-1:0] tag_set_t;  // way 0 in the low bits

    typedef struct packed {
        cache_addr_t addr;
        logic        write;
        word_t       wdata;
        word_t       wmask;  // bit mask, one bit per data bit
    } cpu_req_t;

    typedef struct packed {
        logic        write;
        cache_addr_t addr;   // always line aligned
        line_t       wline;
    } mem_req_t;

    typedef struct packed {
        logic             hit;
        logic             hit_way;
        logic             victim_way;
        logic             victim_dirty;
        logic [tag_w-1:0] victim_tag;
    } lookup_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        hit_write,
        write_back,
        refill_fetch,
        refill
    } state_t;

endpackage

`default_nettype wire
